/* src/lvda_pkg.sv */
`default_nettype none

package lvda_pkg;

    // Delay-line taps W, X, Y and Z, one per phase of a bit time.
    localparam int NUM_TAPS = 4;

    // Flop depth ahead of the edge detector.
    localparam int SYNC_STAGES = 2;

    // Bit times G1D to G7D in one word.
    localparam int NUM_BITS = 7;

    // Positions in the gd one-hot.
    localparam int G1D_IDX = 0;
    localparam int G2D_IDX = 1;
    localparam int G7D_IDX = NUM_BITS - 1;

    // gd selects G1D out of reset.
    localparam logic [NUM_BITS-1:0] GD_RESET = NUM_BITS'(1) << G1D_IDX;

    // Expected next tap in the W-X-Y-Z rotation.
    typedef enum logic [1:0] {
        PH_W = 2'd0,
        PH_X = 2'd1,
        PH_Y = 2'd2,
        PH_Z = 2'd3
    } phase_t;

    // Computer phase, advanced once per word.
    typedef enum logic [1:0] {
        CYC_A = 2'd0,
        CYC_B = 2'd1,
        CYC_C = 2'd2
    } cycle_t;

    // Tap order as bit positions in the packed tap vector.
    localparam int TAP_W = 0;
    localparam int TAP_X = 1;
    localparam int TAP_Y = 2;
    localparam int TAP_Z = 3;

endpackage

`default_nettype wire

/* src/phase_gen.sv */
`default_nettype none

module phase_gen import lvda_pkg::*; (
    input  logic sim_clk,
    input  logic rst_n,
    input  logic wda,
    input  logic xda,
    input  logic yda,
    input  logic zda,
    output logic w3,
    output logic x3,
    output logic y3,
    output logic z1,
    output logic phase_err
);

    logic [NUM_TAPS-1:0]                  taps;
    logic [SYNC_STAGES-1:0][NUM_TAPS-1:0] sync_q;
    logic [NUM_TAPS-1:0]                  prev_q;
    logic [NUM_TAPS-1:0]                  rise;
    logic [NUM_TAPS-1:0]                  expect_mask;
    logic [NUM_TAPS-1:0]                  pulse_q;
    logic                                 hit;
    logic                                 stray;
    phase_t                               state_q;
    phase_t                               state_d;

    assign taps = {zda, yda, xda, wda};

    // Taps are asynchronous to sim_clk.
    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            sync_q <= '0;
            prev_q <= '0;
        end else begin
            sync_q[0] <= taps;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            prev_q <= sync_q[SYNC_STAGES-1];
        end
    end

    assign rise        = sync_q[SYNC_STAGES-1] & ~prev_q;
    assign expect_mask = NUM_TAPS'(1) << state_q;
    assign hit         = |(rise & expect_mask);
    assign stray       = |(rise & ~expect_mask); // Any edge out of turn.

    always_comb begin
        case (state_q)
            PH_W:    state_d = PH_X;
            PH_X:    state_d = PH_Y;
            PH_Y:    state_d = PH_Z;
            default: state_d = PH_W;
        endcase
    end

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            state_q   <= PH_W;
            pulse_q   <= '0;
            phase_err <= 1'b0;
        end else begin
            pulse_q <= rise & expect_mask; // Only the expected tap may pulse.
            if (hit) begin
                state_q <= state_d;
            end
            if (stray) begin
                phase_err <= 1'b1; // Held until reset.
            end
        end
    end

    assign w3 = pulse_q[TAP_W];
    assign x3 = pulse_q[TAP_X];
    assign y3 = pulse_q[TAP_Y];
    assign z1 = pulse_q[TAP_Z];

    assert property (@(posedge sim_clk) disable iff (!rst_n) $onehot0({w3, x3, y3, z1}))
        else $error("phase_gen: more than one phase pulse in a cycle");

endmodule

`default_nettype wire

/* src/bit_timer.sv */
`default_nettype none

module bit_timer import lvda_pkg::*; (
    input  logic                sim_clk,
    input  logic                rst_n,
    input  logic                z1,
    output logic [NUM_BITS-1:0] gd,
    output logic                word_end
);

    logic [NUM_BITS-1:0] gd_q;
    logic [NUM_BITS-1:0] gd_next;
    logic                last_bit;
    logic                word_end_q;

    // G7D is the final bit time of a word.
    assign last_bit = gd_q[G7D_IDX];

    // Rotate left, G7D wraps round to G1D.
    assign gd_next = {gd_q[NUM_BITS-2:0], gd_q[G7D_IDX]};

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            gd_q <= GD_RESET;
        end else if (z1) begin
            gd_q <= gd_next;
        end
    end

    // Strobe lines up with the wrap to G1D.
    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            word_end_q <= 1'b0;
        end else begin
            word_end_q <= z1 && last_bit;
        end
    end

    assign gd       = gd_q;
    assign word_end = word_end_q;

    assert property (@(posedge sim_clk) disable iff (!rst_n) $onehot(gd))
        else $error("bit_timer: gd not one-hot (%b)", gd);

endmodule

`default_nettype wire

/* src/cycle_timer.sv */
`default_nettype none

module cycle_timer import lvda_pkg::*; (
    input  logic                sim_clk,
    input  logic                rst_n,
    input  logic                word_end,
    input  logic [NUM_BITS-1:0] gd,
    output logic                pa,
    output logic                pb,
    output logic                pc,
    output logic                pcg2,
    output logic                resm
);

    cycle_t state_q;
    cycle_t state_d;
    logic   resm_q;
    logic   wrap;

    always_comb begin
        case (state_q)
            CYC_A:   state_d = CYC_B;
            CYC_B:   state_d = CYC_C;
            default: state_d = CYC_A; // C goes back to A.
        endcase
    end

    assign wrap = word_end && (state_q == CYC_C);

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            state_q <= CYC_A;
        end else if (word_end) begin
            state_q <= state_d;
        end
    end

    // Reset mode lasts one full A-B-C cycle.
    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            resm_q <= 1'b1;
        end else if (wrap) begin
            resm_q <= 1'b0;
        end
    end

    assign pa   = (state_q == CYC_A);
    assign pb   = (state_q == CYC_B);
    assign pc   = (state_q == CYC_C);
    assign pcg2 = pc && gd[G2D_IDX]; // PC at G2.
    assign resm = resm_q;

    assert property (@(posedge sim_clk) disable iff (!rst_n) $onehot({pa, pb, pc}))
        else $error("cycle_timer: A/B/C phases not one-hot");

endmodule

`default_nettype wire

/* src/lvda_timing.sv */
`default_nettype none

module lvda_timing import lvda_pkg::*; (
    input  logic                sim_clk,
    input  logic                rst_n,
    input  logic                wda,
    input  logic                xda,
    input  logic                yda,
    input  logic                zda,
    output logic                w3,
    output logic                x3,
    output logic                y3,
    output logic                z1,
    output logic                phase_err,
    output logic [NUM_BITS-1:0] gd,
    output logic                word_end,
    output logic                pa,
    output logic                pb,
    output logic                pc,
    output logic                pcg2,
    output logic                resm
);

    // Taps to W3, X3, Y3 and Z1.
    phase_gen phase_gen0 (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .wda       (wda),
        .xda       (xda),
        .yda       (yda),
        .zda       (zda),
        .w3        (w3),
        .x3        (x3),
        .y3        (y3),
        .z1        (z1),
        .phase_err (phase_err)
    );

    // Z1 to G1D..G7D.
    bit_timer bit_timer0 (
        .sim_clk  (sim_clk),
        .rst_n    (rst_n),
        .z1       (z1),
        .gd       (gd),
        .word_end (word_end)
    );

    cycle_timer cycle_timer0 (
        .sim_clk  (sim_clk),
        .rst_n    (rst_n),
        .word_end (word_end),
        .gd       (gd),
        .pa       (pa),
        .pb       (pb),
        .pc       (pc),
        .pcg2     (pcg2),
        .resm     (resm)
    );

endmodule

`default_nettype wire

/* tb/lvda_checks.svh */
`ifndef LVDA_CHECKS_SVH
`define LVDA_CHECKS_SVH

int error_count     = 0;
int check_count     = 0;
int test_count      = 0;
int failed_tests    = 0;
int errors_at_start = 0;

task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    check_count++;
    if (got !== want) begin
        error_count++;
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
    end
endtask

task automatic begin_test();
    errors_at_start = error_count;
endtask

task automatic end_test(input string name);
    test_count++;
    if (error_count == errors_at_start) begin
        $display("test %s: ok", name);
    end else begin
        failed_tests++;
        $display("test %s: %0d errors", name, error_count - errors_at_start);
    end
endtask

// Phase pulse on one tap, at most limit cycles away.
task automatic wait_for_pulse(input int tap, input int limit, output int waited);
    logic found;
    found  = 1'b0;
    waited = limit;
    for (int i = 0; i < limit && !found; i++) begin
        @(negedge sim_clk);
        if (pulses[tap]) begin
            found  = 1'b1;
            waited = i;
        end
    end
    if (!found) begin
        error_count++;
        $display("timeout: tap %0d gave no phase pulse within %0d cycles", tap, limit);
    end
endtask

`endif

/* tb/tb_lvda.sv */
`default_nettype none

module tb_lvda import lvda_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PULSE_LATENCY = 3; // Drive edge to phase pulse.
    localparam int PULSE_TIMEOUT = 8;

    logic                sim_clk = 1'b0;
    logic                rst_n;
    logic                wda, xda, yda, zda;
    logic                w3, x3, y3, z1, phase_err, word_end, pa, pb, pc, pcg2, resm;
    logic [NUM_BITS-1:0] gd;
    logic [NUM_TAPS-1:0] pulses;
    integer              seed = 32'h3ec3;

    // Reference model.
    phase_t              m_phase;
    cycle_t              m_cyc;
    int                  m_bit;
    logic [NUM_TAPS-1:0] m_pulse;
    logic [NUM_TAPS-1:0] m_prev_taps;
    logic [NUM_TAPS:0]   m_pipe [PULSE_LATENCY]; // Top bit flags an order error.
    logic                m_word_end, m_err, m_resm;
    logic                rst_seen = 1'b0;
    int                  pulse_seen = 0, z1_seen = 0, words_seen = 0;

    assign pulses = {z1, y3, x3, w3};

    lvda_timing dut0 (.*);

    `include "lvda_checks.svh"

    initial begin
        forever #2 sim_clk = ~sim_clk;
    end

    always @(negedge sim_clk) begin
        logic [NUM_TAPS-1:0] rise;
        logic [NUM_TAPS-1:0] want;
        if (!rst_seen) begin
            m_phase     = PH_W;
            m_cyc       = CYC_A;
            m_bit       = 0;
            m_pulse     = '0;
            m_prev_taps = '0;
            m_word_end  = 1'b0;
            m_err       = 1'b0;
            m_resm      = 1'b1;
            for (int i = 0; i < PULSE_LATENCY; i++) begin
                m_pipe[i] = '0;
            end
        end else begin
            if (m_word_end) begin
                if (m_cyc == CYC_C) begin
                    m_resm = 1'b0;
                end
                m_cyc = cycle_t'((int'(m_cyc) + 1) % 3);
            end
            m_word_end = 1'b0;
            if (m_pulse[TAP_Z]) begin
                m_bit      = (m_bit + 1) % NUM_BITS;
                m_word_end = (m_bit == 0); // Back at G1D.
            end
            m_pulse = m_pipe[PULSE_LATENCY-1][NUM_TAPS-1:0];
            m_err   = m_err | m_pipe[PULSE_LATENCY-1][NUM_TAPS];
            for (int i = PULSE_LATENCY - 1; i > 0; i--) begin
                m_pipe[i] = m_pipe[i-1];
            end
        end
        rise      = {zda, yda, xda, wda} & ~m_prev_taps;
        want      = NUM_TAPS'(1) << m_phase;
        m_pipe[0] = {|(rise & ~want), rise & want};
        if (|(rise & want)) begin
            m_phase = phase_t'((int'(m_phase) + 1) % NUM_TAPS);
        end
        m_prev_taps = {zda, yda, xda, wda};
        rst_seen    = rst_n;

        if (pulses != '0) pulse_seen++;
        if (z1) z1_seen++;
        if (word_end) words_seen++;

        compare("w3", 32'(w3), 32'(m_pulse[TAP_W]));
        compare("x3", 32'(x3), 32'(m_pulse[TAP_X]));
        compare("y3", 32'(y3), 32'(m_pulse[TAP_Y]));
        compare("z1", 32'(z1), 32'(m_pulse[TAP_Z]));
        compare("phase_err", 32'(phase_err), 32'(m_err));
        compare("gd", 32'(gd), 32'(NUM_BITS'(1) << m_bit));
        compare("word_end", 32'(word_end), 32'(m_word_end));
        compare("pa", 32'(pa), 32'(m_cyc == CYC_A));
        compare("pb", 32'(pb), 32'(m_cyc == CYC_B));
        compare("pc", 32'(pc), 32'(m_cyc == CYC_C));
        compare("pcg2", 32'(pcg2), 32'(m_cyc == CYC_C && m_bit == G2D_IDX));
        compare("resm", 32'(resm), 32'(m_resm));
    end

    task automatic check_reset_state();
        compare("phase pulses", 32'(pulses), 0);
        compare("phase_err", 32'(phase_err), 0);
        compare("gd", 32'(gd), 1);
        compare("word_end", 32'(word_end), 0);
        compare("pa/pb/pc", 32'({pa, pb, pc}), 32'h4);
        compare("pcg2", 32'(pcg2), 0);
        compare("resm", 32'(resm), 1);
    endtask

    // High for 4 to 9 clocks, then low for 1 to 4.
    task automatic drive_tap(input int tap, input logic in_order);
        int hold;
        int low;
        int waited;
        hold   = 4 + int'($unsigned($random(seed)) % 6);
        low    = 1 + int'($unsigned($random(seed)) % 4);
        waited = 0;
        @(posedge sim_clk);
        {zda, yda, xda, wda} <= NUM_TAPS'(1) << tap;
        if (in_order) begin
            wait_for_pulse(tap, PULSE_TIMEOUT, waited);
            compare($sformatf("tap %0d latency", tap), waited, PULSE_LATENCY);
        end
        for (int k = waited + 1; k < hold; k++) begin
            @(posedge sim_clk);
        end
        @(posedge sim_clk);
        {zda, yda, xda, wda} <= '0;
        for (int k = 1; k < low; k++) begin
            @(posedge sim_clk);
        end
    endtask

    task automatic run_taps(input int count);
        for (int i = 0; i < count; i++) begin
            drive_tap(int'(m_phase), 1'b1);
        end
        @(negedge sim_clk);
    endtask

    initial begin
        logic [NUM_BITS-1:0] gd_before;
        logic [2:0]          abc_before;
        int                  pulses_before;
        rst_n <= 1'b0;
        {zda, yda, xda, wda} <= '0;
        repeat (10) @(posedge sim_clk);
        rst_n <= 1'b1;
        repeat (2) @(negedge sim_clk);

        begin_test();
        check_reset_state();
        end_test("reset_state");

        begin_test();
        pulses_before = pulse_seen;
        run_taps(8);
        compare("phase pulse count", pulse_seen - pulses_before, 8);
        end_test("phase_pulses");

        begin_test();
        run_taps(48); // Two full words by now.
        compare("z1 count", z1_seen, 14);
        compare("word_end count", words_seen, 14 / NUM_BITS);
        compare("gd", 32'(gd), 32'(NUM_BITS'(1) << (14 % NUM_BITS)));
        end_test("bit_counting");

        begin_test();
        compare("resm", 32'(resm), 1);
        run_taps(28);
        compare("word count", words_seen, 3);
        compare("pa/pb/pc", 32'({pa, pb, pc}), 32'h4); // Three words, back at A.
        compare("resm", 32'(resm), 0);
        end_test("cycle_phases");

        begin_test();
        gd_before     = gd;
        abc_before    = {pa, pb, pc};
        pulses_before = pulse_seen;
        drive_tap((int'(m_phase) + 1 + int'($unsigned($random(seed)) % 3)) % NUM_TAPS, 1'b0);
        @(negedge sim_clk);
        compare("phase_err", 32'(phase_err), 1);
        compare("phase pulse count", pulse_seen - pulses_before, 0);
        compare("gd", 32'(gd), 32'(gd_before));
        compare("pa/pb/pc", 32'({pa, pb, pc}), 32'(abc_before));
        run_taps(6);
        compare("phase_err", 32'(phase_err), 1); // Sticky.
        end_test("order_error");

        begin_test();
        @(posedge sim_clk);
        {zda, yda, xda, wda} <= NUM_TAPS'(1) << m_phase;
        repeat (2) @(posedge sim_clk);
        rst_n <= 1'b0; // Tap still in the synchronizer.
        {zda, yda, xda, wda} <= '0;
        repeat (10) @(posedge sim_clk);
        rst_n <= 1'b1;
        repeat (2) @(negedge sim_clk);
        check_reset_state();
        end_test("reset_mid_run");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+tb
src/lvda_pkg.sv
src/phase_gen.sv
src/bit_timer.sv
src/cycle_timer.sv
src/lvda_timing.sv
tb/tb_lvda.sv

/* run.sh */
#!/bin/sh
# Compile and run the LVDA timing testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_lvda --Mdir obj_dir -o tb_lvda -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_lvda)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx 'STATUS: PASS'; then
    exit 0
fi
echo "Pass message not found"
exit 1
